// File: hw/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// word widths.
`define ADDR_WIDTH 32
`define INSTR_WIDTH 32
`define REG_ADDR_WIDTH 5

// buffer sizing.
`define BUFFER_DEPTH 8 // power of two, pointers wrap.
`define STALL_LEVEL (`BUFFER_DEPTH / 2) // leaves room for one more pair.

// issued in place of a slot that is not taken.
`define NOP_INSTR 32'h0000_0013 // addi x0, x0, 0.

`endif

// File: hw/issue_pkg.sv
`include "issue_settings.svh"

package issue_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`INSTR_WIDTH-1:0] instr_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [2*`INSTR_WIDTH-1:0] fetch_word_t; // lower word first.
  typedef logic [1:0] issue_count_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam opcode_t OPCODE_LUI       = 7'b0110111;
  localparam opcode_t OPCODE_AUIPC     = 7'b0010111;
  localparam opcode_t OPCODE_JAL       = 7'b1101111;
  localparam opcode_t OPCODE_JALR      = 7'b1100111;
  localparam opcode_t OPCODE_BRANCH    = 7'b1100011;
  localparam opcode_t OPCODE_LOAD      = 7'b0000011;
  localparam opcode_t OPCODE_STORE     = 7'b0100011;
  localparam opcode_t OPCODE_IMMEDIATE = 7'b0010011;
  localparam opcode_t OPCODE_REGISTER  = 7'b0110011;
  localparam opcode_t OPCODE_FENCE     = 7'b0001111;
  localparam opcode_t OPCODE_SYSTEM    = 7'b1110011;

  localparam funct3_t FUNCT_ADD  = 3'b000;
  localparam funct3_t FUNCT_SLL  = 3'b001;
  localparam funct3_t FUNCT_SLT  = 3'b010;
  localparam funct3_t FUNCT_SLTU = 3'b011;
  localparam funct3_t FUNCT_XOR  = 3'b100;
  localparam funct3_t FUNCT_SRL  = 3'b101;
  localparam funct3_t FUNCT_OR   = 3'b110;
  localparam funct3_t FUNCT_AND  = 3'b111;

  localparam funct7_t FUNCT7_ZERO = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000; // sub and arithmetic shift.

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
  } buffer_entry_t;

  typedef struct packed {
    logic      basic;
    logic      complex;
    logic      wren;
    logic      rden1;
    logic      rden2;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } slot_class_t;

  typedef struct packed {
    addr_t  pc;
    addr_t  npc;
    instr_t instr;
  } issue_slot_t;

endpackage

// File: hw/fetch_buffer.sv
`include "issue_settings.svh"

module fetch_buffer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clear,
  input  logic                     fetch_ready,
  input  issue_pkg::addr_t         fetch_pc,
  input  issue_pkg::fetch_word_t   fetch_data,
  input  issue_pkg::issue_count_t  take,
  output issue_pkg::buffer_entry_t head0,
  output issue_pkg::buffer_entry_t head1,
  output logic                     stall
);
  import issue_pkg::*;

  localparam int PTR_W = $clog2(`BUFFER_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0] count_t;

  addr_t  pc_mem [`BUFFER_DEPTH];
  instr_t instr_mem [`BUFFER_DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   stall_reg;

  logic   accept;
  ptr_t   wr_ptr_hi;
  ptr_t   rd_ptr_hi;
  ptr_t   wr_ptr_next;
  ptr_t   rd_ptr_next;
  count_t count_in;
  count_t count_next;
  addr_t  pc_hi;
  instr_t word_lo;
  instr_t word_hi;

  // entry at idx, with the pair being written this cycle forwarded.
  function automatic buffer_entry_t view(ptr_t idx, logic valid);
    buffer_entry_t e;
    e.valid = valid;
    if (accept && idx == wr_ptr) begin
      e.pc = fetch_pc;
      e.instr = word_lo;
    end else if (accept && idx == wr_ptr_hi) begin
      e.pc = pc_hi;
      e.instr = word_hi;
    end else begin
      e.pc = pc_mem[idx];
      e.instr = instr_mem[idx];
    end
    return e;
  endfunction

  always_comb begin
    accept = fetch_ready && !stall_reg && !clear; // dropped while stalled.
    word_lo = fetch_data[`INSTR_WIDTH-1:0];
    word_hi = fetch_data[2*`INSTR_WIDTH-1:`INSTR_WIDTH];
    pc_hi = fetch_pc + addr_t'(4);
    wr_ptr_hi = wr_ptr + ptr_t'(1);
    rd_ptr_hi = rd_ptr + ptr_t'(1);

    count_in = clear ? '0 : count + (accept ? count_t'(2) : count_t'(0));

    head0 = view(rd_ptr, count_in != '0);
    head1 = view(rd_ptr_hi, count_in > count_t'(1));

    count_next = count_in - count_t'(take);
    wr_ptr_next = clear ? '0 : (accept ? wr_ptr + ptr_t'(2) : wr_ptr);
    rd_ptr_next = clear ? '0 : rd_ptr + ptr_t'(take);
    stall = count_next > count_t'(`STALL_LEVEL);
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc_mem[wr_ptr] <= fetch_pc;
      instr_mem[wr_ptr] <= word_lo;
      pc_mem[wr_ptr_hi] <= pc_hi;
      instr_mem[wr_ptr_hi] <= word_hi;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      stall_reg <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;
      count <= count_next;
      stall_reg <= stall;
    end
  end

endmodule

// File: hw/slot_decoder.sv
module slot_decoder (
  input  issue_pkg::buffer_entry_t entry,
  output issue_pkg::slot_class_t   cls
);
  import issue_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rd_nonzero;

  always_comb begin
    opcode = entry.instr[6:0];
    rd = entry.instr[11:7];
    funct3 = entry.instr[14:12];
    rs1 = entry.instr[19:15];
    rs2 = entry.instr[24:20];
    funct7 = entry.instr[31:25];
    rd_nonzero = |rd;

    cls = '0;

    if (entry.valid) begin
      cls.waddr = rd;
      cls.raddr1 = rs1;
      cls.raddr2 = rs2;

      case (opcode)
        OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: begin
          cls.complex = 1'b1;
          cls.wren = rd_nonzero;
        end
        OPCODE_JALR, OPCODE_LOAD: begin
          cls.complex = 1'b1;
          cls.wren = rd_nonzero;
          cls.rden1 = 1'b1;
        end
        OPCODE_BRANCH, OPCODE_STORE: begin
          cls.complex = 1'b1;
          cls.rden1 = 1'b1;
          cls.rden2 = 1'b1;
        end
        OPCODE_IMMEDIATE: begin
          case (funct3)
            FUNCT_ADD, FUNCT_SLT, FUNCT_SLTU,
            FUNCT_XOR, FUNCT_OR, FUNCT_AND: begin
              cls.basic = 1'b1;
            end
            FUNCT_SLL: begin
              cls.basic = (funct7 == FUNCT7_ZERO);
            end
            default: begin // srli and srai.
              cls.basic = (funct7 == FUNCT7_ZERO) || (funct7 == FUNCT7_ALT);
            end
          endcase
          cls.complex = !cls.basic; // illegal shift encodings.
          cls.wren = rd_nonzero;
          cls.rden1 = 1'b1;
        end
        OPCODE_REGISTER: begin
          if (funct7 == FUNCT7_ZERO) begin
            cls.basic = 1'b1;
          end else if (funct7 == FUNCT7_ALT) begin
            cls.basic = (funct3 == FUNCT_ADD) || (funct3 == FUNCT_SRL);
          end
          cls.complex = !cls.basic;
          cls.wren = rd_nonzero;
          cls.rden1 = 1'b1;
          cls.rden2 = 1'b1;
        end
        OPCODE_FENCE: begin
          cls.complex = 1'b1;
        end
        OPCODE_SYSTEM: begin
          cls.complex = 1'b1;
          cls.wren = rd_nonzero;
        end
        default: begin
          // unknown, float included; issued alone.
        end
      endcase
    end
  end

endmodule

// File: hw/issue_select.sv
`include "issue_settings.svh"

module issue_select (
  input  issue_pkg::buffer_entry_t head0,
  input  issue_pkg::buffer_entry_t head1,
  input  issue_pkg::slot_class_t   cls0,
  input  issue_pkg::slot_class_t   cls1,
  input  logic                     hold,
  output issue_pkg::issue_count_t  take,
  output issue_pkg::issue_slot_t   issue0,
  output issue_pkg::issue_slot_t   issue1
);
  import issue_pkg::*;

  issue_count_t base;
  issue_count_t avail;
  logic         raw;

  function automatic issue_slot_t build_slot(buffer_entry_t head, logic issued);
    issue_slot_t s;
    s.pc = '0;
    s.npc = '0;
    s.instr = `NOP_INSTR;
    if (issued) begin
      s.pc = head.pc;
      s.npc = head.pc + ((head.instr[1:0] == 2'b11) ? addr_t'(4) : addr_t'(2));
      s.instr = head.instr;
    end
    return s;
  endfunction

  always_comb begin
    // slot 1 reads what slot 0 writes.
    raw = cls0.wren &&
          ((cls1.rden1 && cls1.raddr1 == cls0.waddr) ||
           (cls1.rden2 && cls1.raddr2 == cls0.waddr));

    if (cls1.basic && (cls0.basic || cls0.complex) && !raw) begin
      base = 2'd2;
    end else begin
      base = 2'd1;
    end

    if (hold) begin
      base = 2'd0;
    end

    avail = head1.valid ? 2'd2 : (head0.valid ? 2'd1 : 2'd0);
    take = (base > avail) ? avail : base;

    issue0 = build_slot(head0, take != 2'd0);
    issue1 = build_slot(head1, take == 2'd2);
  end

endmodule

// File: hw/dual_issue_front.sv
module dual_issue_front (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_ready,
  input  issue_pkg::addr_t       fetch_pc,
  input  issue_pkg::fetch_word_t fetch_data,
  input  logic                   hold,
  input  logic                   clear,
  output issue_pkg::issue_slot_t issue0,
  output issue_pkg::issue_slot_t issue1,
  output logic                   stall
);
  import issue_pkg::*;

  buffer_entry_t head0;
  buffer_entry_t head1;
  slot_class_t   cls0;
  slot_class_t   cls1;
  issue_count_t  take;

  fetch_buffer buffer (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .take        (take),
    .head0       (head0),
    .head1       (head1),
    .stall       (stall)
  );

  slot_decoder slot0_decoder (.entry(head0), .cls(cls0));
  slot_decoder slot1_decoder (.entry(head1), .cls(cls1));

  issue_select select (
    .head0  (head0),
    .head1  (head1),
    .cls0   (cls0),
    .cls1   (cls1),
    .hold   (hold),
    .take   (take),
    .issue0 (issue0),
    .issue1 (issue1)
  );

endmodule

// File: verification/dual_issue_front_tb.sv
`include "issue_settings.svh"

module dual_issue_front_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import issue_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_ROWS = 12;
  localparam int FILL_CYCLES = 10;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 3 + FILL_CYCLES + 20;
  localparam addr_t FILL_PC = 32'h0000_2000;

  localparam instr_t ADDI_X1 = 32'h0050_0093; // addi x1, x0, 5.
  localparam instr_t ADDI_X2 = 32'h0070_0113; // addi x2, x0, 7.
  localparam instr_t ADDI_X0 = 32'h0050_0013; // addi x0, x0, 5.
  localparam instr_t ADDI_X6 = 32'h0010_0313; // addi x6, x0, 1.
  localparam instr_t ADD_X1 = 32'h0020_81B3; // add x3, x1, x2.
  localparam instr_t ADD_X0 = 32'h0020_01B3; // add x3, x0, x2.
  localparam instr_t SUB_X3 = 32'h4020_81B3; // sub x3, x1, x2.
  localparam instr_t MUL_X3 = 32'h0220_81B3; // funct7 not basic.
  localparam instr_t LW_X5 = 32'h0000_A283; // lw x5, 0(x1).
  localparam instr_t BEQ = 32'h0020_8063; // beq x1, x2, 0.
  localparam instr_t FLW = 32'h0000_A087; // float load is unknown here.
  localparam instr_t C_NOP = 32'h0000_0001; // compressed encoding.

  typedef struct packed {
    addr_t        pc;
    instr_t       word0;
    instr_t       word1;
    logic         hold;
    issue_count_t take;
    addr_t        npc0;
    addr_t        npc1;
  } table_row_t;

  logic        clock;
  logic        reset;
  logic        fetch_ready;
  addr_t       fetch_pc;
  fetch_word_t fetch_data;
  logic        hold;
  logic        clear;
  issue_slot_t issue0;
  issue_slot_t issue1;
  logic        stall;

  table_row_t table_rows [NUM_ROWS];
  int         row_fill;
  int         cycle_count;

  dual_issue_front uut (
    .clock       (clock),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .hold        (hold),
    .clear       (clear),
    .issue0      (issue0),
    .issue1      (issue1),
    .stall       (stall)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("sim failed");
      $fatal(1, "timeout reached");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_slot(input string name, input issue_slot_t actual, input logic issued,
                            input addr_t pc, input addr_t npc, input instr_t instr);
    addr_t  exp_pc;
    addr_t  exp_npc;
    instr_t exp_instr;
    exp_pc = issued ? pc : 32'd0;
    exp_npc = issued ? npc : 32'd0;
    exp_instr = issued ? instr : `NOP_INSTR;
    check_value({name, ".pc"}, actual.pc, exp_pc);
    check_value({name, ".npc"}, actual.npc, exp_npc);
    check_value({name, ".instr"}, actual.instr, exp_instr);
  endtask

  task automatic add_row(input addr_t pc, input instr_t word0, input instr_t word1,
                         input logic hold_level, input issue_count_t take,
                         input addr_t npc0, input addr_t npc1);
    table_rows[row_fill] = {pc, word0, word1, hold_level, take, npc0, npc1};
    row_fill++;
  endtask

  task automatic do_clear();
    @(posedge clock);
    clear <= 1'b1;
    fetch_ready <= 1'b0;
    hold <= 1'b0;
  endtask

  task automatic run_row(input int idx);
    table_row_t r;
    r = table_rows[idx];
    do_clear();
    @(posedge clock);
    clear <= 1'b0;
    fetch_ready <= 1'b1;
    fetch_pc <= r.pc;
    fetch_data <= {r.word1, r.word0};
    hold <= r.hold;
    #(CLK_PERIOD - 1); // just before the next edge.
    check_slot($sformatf("row %0d issue0", idx), issue0, r.take != 2'd0, r.pc, r.npc0,
               r.word0);
    check_slot($sformatf("row %0d issue1", idx), issue1, r.take == 2'd2, r.pc + 32'd4,
               r.npc1, r.word1);
    check_value($sformatf("row %0d stall", idx), stall, 1'b0);
  endtask

  task automatic fill_test();
    do_clear();
    for (int p = 0; p < 4; p++) begin
      @(posedge clock);
      clear <= 1'b0;
      fetch_ready <= 1'b1;
      hold <= 1'b1;
      fetch_pc <= FILL_PC + 32'(p * 8);
      fetch_data <= {ADDI_X2, ADDI_X1};
      #(CLK_PERIOD - 1);
      check_slot($sformatf("fill %0d issue0", p), issue0, 1'b0, 32'd0, 32'd0, ADDI_X1);
      check_slot($sformatf("fill %0d issue1", p), issue1, 1'b0, 32'd0, 32'd0, ADDI_X2);
      check_value($sformatf("fill %0d stall", p), stall, p >= 2); // third pair passes level.
    end
    for (int p = 0; p < 4; p++) begin
      @(posedge clock);
      fetch_ready <= 1'b0;
      hold <= 1'b0;
      #(CLK_PERIOD - 1);
      check_slot($sformatf("drain %0d issue0", p), issue0, p < 3, FILL_PC + 32'(p * 8),
                 FILL_PC + 32'(p * 8 + 4), ADDI_X1);
      check_slot($sformatf("drain %0d issue1", p), issue1, p < 3, FILL_PC + 32'(p * 8 + 4),
                 FILL_PC + 32'(p * 8 + 8), ADDI_X2); // fourth pair was dropped.
      check_value($sformatf("drain %0d stall", p), stall, 1'b0);
    end
  endtask

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    fetch_ready = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    hold = 1'b0;
    row_fill = 0;
    cycle_count = 0;

    add_row(32'h0000_1000, ADDI_X1, ADDI_X2, 1'b0, 2'd2, 32'h1004, 32'h1008);
    add_row(32'h0000_1040, ADDI_X1, ADD_X1, 1'b0, 2'd1, 32'h1044, 32'h1048); // raw on x1.
    add_row(32'h0000_1080, ADDI_X0, ADD_X0, 1'b0, 2'd2, 32'h1084, 32'h1088);
    add_row(32'h0000_10c0, LW_X5, ADDI_X2, 1'b0, 2'd2, 32'h10c4, 32'h10c8);
    add_row(32'h0000_1100, BEQ, ADDI_X2, 1'b0, 2'd2, 32'h1104, 32'h1108);
    add_row(32'h0000_1140, ADDI_X1, BEQ, 1'b0, 2'd1, 32'h1144, 32'h1148);
    add_row(32'h0000_1180, LW_X5, BEQ, 1'b0, 2'd1, 32'h1184, 32'h1188);
    add_row(32'h0000_11c0, FLW, ADDI_X2, 1'b0, 2'd1, 32'h11c4, 32'h11c8);
    add_row(32'h0000_1200, C_NOP, ADDI_X2, 1'b0, 2'd1, 32'h1202, 32'h1208);
    add_row(32'h0000_1240, ADDI_X1, ADDI_X2, 1'b1, 2'd0, 32'h1244, 32'h1248);
    add_row(32'h0000_1280, SUB_X3, ADDI_X6, 1'b0, 2'd2, 32'h1284, 32'h1288);
    add_row(32'h0000_12c0, ADDI_X1, MUL_X3, 1'b0, 2'd1, 32'h12c4, 32'h12c8);

    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    #(CLK_PERIOD - 1);
    check_slot("reset issue0", issue0, 1'b0, 32'd0, 32'd0, ADDI_X1);
    check_slot("reset issue1", issue1, 1'b0, 32'd0, 32'd0, ADDI_X2);
    check_value("reset stall", stall, 1'b0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    fill_test();

    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/issue_pkg.sv
hw/fetch_buffer.sv
hw/slot_decoder.sv
hw/issue_select.sv
hw/dual_issue_front.sv
verification/dual_issue_front_tb.sv
